// ==== mcr_input_pkg.sv ====
//====================
// Shared constants and types for the MCR-3 control-input block.
// Button bit positions, game codes, the Max RPM gear table, timing
// constants and the input-port byte type. Modules import it in their body.
//====================
package mcr_input_pkg;

	// Digital joystick word from the frontend
	localparam int JOY_W      = 12;
	localparam int BTN_RIGHT  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_DOWN   = 2;
	localparam int BTN_UP     = 3;
	localparam int BTN_FIRE_A = 4;
	localparam int BTN_FIRE_B = 5;
	localparam int BTN_FIRE_C = 6;
	localparam int BTN_FIRE_D = 7;
	localparam int BTN_START  = 8;
	localparam int BTN_COIN   = 9;

	// Analog stick word, pedal flag in bit 15, Y in 14:8, signed X in 7:0
	localparam int ANA_W = 16;

	// Configuration and game selection
	localparam logic [7:0] CFG_INDEX_GAME  = 8'd1;
	localparam logic [7:0] GAME_POWERDRIVE = 8'd2;
	localparam logic [7:0] GAME_MAXRPM     = 8'd3;

	// Max RPM gearbox
	localparam int NUM_GEARS = 5;
	localparam int GEAR_W    = 3;
	// Switch pattern the shifter presents in each gear
	localparam logic [3:0] GEAR_CODES [NUM_GEARS] = '{4'h0, 4'h5, 4'h6, 4'h1, 4'h2};

	// Steering pot reading with the wheel straight
	localparam logic [7:0] STEER_CENTER = 8'h74;

	// Cycles from end of ROM download to the second reset pulse
	localparam logic [7:0] HOLDOFF_CYCLES = 8'd255;

	// One input-port byte, seen whole or as two nibbles
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [3:0] high;
			logic [3:0] low;
		} nibbles;
	} port_byte_u;

endpackage

// ==== gearbox_fsm.sv ====
//====================
// Five-gear shifter for one Max RPM player.
// Rising shift_up and shift_down step the gear, neutral forces gear 0.
//====================
`timescale 1ns/1ps

module gearbox_fsm (
	input  logic                             clk_sys,
	input  logic                             core_reset,
	input  logic                             shift_up,
	input  logic                             shift_down,
	input  logic                             neutral,
	output logic [mcr_input_pkg::GEAR_W-1:0] gear
);
	import mcr_input_pkg::*;

	localparam logic [GEAR_W-1:0] TOP_GEAR = GEAR_W'(NUM_GEARS - 1);

	logic up_last;
	logic down_last;
	logic up_rise;
	logic down_rise;

	// Edge detect against the previous sample
	assign up_rise   = shift_up & ~up_last;
	assign down_rise = shift_down & ~down_last;

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			up_last   <= 1'b0;
			down_last <= 1'b0;
			gear      <= '0;
		end else begin
			up_last   <= shift_up;
			down_last <= shift_down;

			if (neutral) begin
				gear <= '0;
			end else if (up_rise) begin
				// Up beats down when both arrive together
				if (gear != TOP_GEAR) begin
					gear <= gear + 1'b1;
				end
			end else if (down_rise) begin
				if (gear != '0) begin
					gear <= gear - 1'b1;
				end
			end
		end
	end

endmodule

// ==== reset_holdoff_timer.sv ====
//====================
// Core reset generator.
// Holds the core in reset until a ROM download has finished, then
// gives one extra single-cycle reset pulse HOLDOFF_CYCLES later.
//====================
`timescale 1ns/1ps

module reset_holdoff_timer (
	input  logic clk_sys,
	input  logic reset,
	input  logic download,
	output logic core_reset
);
	import mcr_input_pkg::*;

	logic       loaded;
	logic       download_last;
	logic [7:0] holdoff_count;
	logic       hold;

	// Any of these keeps the core down and the counter parked
	assign hold = reset | download | ~loaded;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loaded        <= 1'b0;
			download_last <= 1'b0;
		end else begin
			download_last <= download;
			// Falling edge of download means the ROM image is complete
			if (download_last & ~download) begin
				loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hold) begin
			holdoff_count <= HOLDOFF_CYCLES;
		end else if (holdoff_count != 8'd0) begin
			holdoff_count <= holdoff_count - 8'd1;
		end
	end

	// Second pulse when the count passes through one, then stays at zero
	assign core_reset = hold | (holdoff_count == 8'd1);

endmodule

// ==== adc_select.sv ====
//====================
// Max RPM pedal and steering ADC.
// The CPU picks a channel through output ports 5 and 6; the selected
// gas or steering value is presented on adc_data in the same cycle.
//====================
`timescale 1ns/1ps

module adc_select (
	input  logic                            clk_sys,
	input  logic                            core_reset,
	input  logic [7:0]                      cpu_out5,
	input  logic [7:0]                      cpu_out6,
	input  logic [mcr_input_pkg::ANA_W-1:0] joy1a,
	input  logic [mcr_input_pkg::ANA_W-1:0] joy2a,
	output logic [7:0]                      adc_data
);
	import mcr_input_pkg::*;

	logic [1:0] adc_control;
	logic [7:0] gas1;
	logic [7:0] gas2;
	logic [7:0] steering1;
	logic [7:0] steering2;

	// Pedal reading, full scale when the stick reports no pedal
	function automatic logic [7:0] pedal(input logic [ANA_W-1:0] stick);
		return stick[15] ? {stick[14:8], 1'b1} : 8'hFF;
	endfunction

	// Half the signed X deflection, sign extended
	function automatic logic [7:0] half_x(input logic [ANA_W-1:0] stick);
		return {stick[7], stick[7:1]};
	endfunction

	// Control latch only loads when both select bits of port 6 are low
	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			adc_control <= 2'b00;
		end else if (cpu_out6[6:5] == 2'b00) begin
			adc_control <= cpu_out5[2:1];
		end
	end

	assign gas1 = pedal(joy1a);
	assign gas2 = pedal(joy2a);

	// Wheels turn in opposite senses, wrap is intended
	assign steering1 = STEER_CENTER - half_x(joy1a);
	assign steering2 = STEER_CENTER + half_x(joy2a);

	always_comb begin
		case (adc_control)
			2'd0:    adc_data = gas2;
			2'd1:    adc_data = gas1;
			2'd2:    adc_data = steering2;
			default: adc_data = steering1;
		endcase
	end

endmodule

// ==== input_port_mux.sv ====
//====================
// Game select register and input ports 0 to 2.
// Holds the Power Drive gear toggles and packs buttons, gears and
// ADC data into the active-low bytes for the selected game.
//====================
`timescale 1ns/1ps

module input_port_mux (
	input  logic                             clk_sys,
	input  logic                             core_reset,
	input  logic                             cfg_wr,
	input  logic [7:0]                       cfg_index,
	input  logic [7:0]                       cfg_data,
	input  logic [mcr_input_pkg::JOY_W-1:0]  joy1,
	input  logic [mcr_input_pkg::JOY_W-1:0]  joy2,
	input  logic [mcr_input_pkg::JOY_W-1:0]  joy3,
	input  logic [mcr_input_pkg::GEAR_W-1:0] gear1,
	input  logic [mcr_input_pkg::GEAR_W-1:0] gear2,
	input  logic [7:0]                       adc_data,
	output mcr_input_pkg::port_byte_u        in_port0,
	output mcr_input_pkg::port_byte_u        in_port1,
	output mcr_input_pkg::port_byte_u        in_port2
);
	import mcr_input_pkg::*;

	logic [7:0] game;
	logic [2:0] pd_toggle;
	logic [2:0] fire_d_last;
	logic [2:0] fire_d;

	assign fire_d = {joy3[BTN_FIRE_D], joy2[BTN_FIRE_D], joy1[BTN_FIRE_D]};

	//====================
	// Registers
	//====================

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			game <= 8'd0;
		end else if (cfg_wr && cfg_index == CFG_INDEX_GAME) begin
			game <= cfg_data;
		end
	end

	// Each fire D press flips that player's high/low gear
	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			pd_toggle   <= 3'b000;
			fire_d_last <= 3'b000;
		end else begin
			fire_d_last <= fire_d;
			pd_toggle   <= pd_toggle ^ (fire_d & ~fire_d_last);
		end
	end

	//====================
	// Port assembly
	//====================

	always_comb begin
		in_port0.raw = 8'hFF;
		in_port1.raw = 8'hFF;
		in_port2.raw = 8'hFF;

		case (game)
			GAME_MAXRPM: begin
				in_port0.raw = ~{4'b0000, joy1[BTN_START], joy2[BTN_START],
					joy1[BTN_COIN], joy2[BTN_COIN]};
				// ADC byte goes out as is
				in_port1.raw = adc_data;
				in_port2.nibbles.high = ~GEAR_CODES[gear1];
				in_port2.nibbles.low  = ~GEAR_CODES[gear2];
			end
			GAME_POWERDRIVE: begin
				in_port0.raw = ~{5'b00000, joy3[BTN_COIN], joy2[BTN_COIN], joy1[BTN_COIN]};
				in_port1.raw = ~{joy2[BTN_FIRE_B], joy2[BTN_FIRE_A], pd_toggle[1],
					joy2[BTN_FIRE_C], joy1[BTN_FIRE_B], joy1[BTN_FIRE_A],
					pd_toggle[0], joy1[BTN_FIRE_C]};
				in_port2.raw = ~{4'b0000, joy3[BTN_FIRE_B], joy3[BTN_FIRE_A],
					pd_toggle[2], joy3[BTN_FIRE_C]};
			end
			default: begin
				// Unknown game leaves every port reading all ones
			end
		endcase
	end

endmodule

// ==== mcr_input_top.sv ====
//====================
// Control-input block of the MCR-3 core.
// Turns joysticks, analog sticks and CPU output latches into input
// ports 0 to 2, and generates the core reset.
//====================
`timescale 1ns/1ps

module mcr_input_top (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            download,
	input  logic                            cfg_wr,
	input  logic [7:0]                      cfg_index,
	input  logic [7:0]                      cfg_data,
	input  logic [mcr_input_pkg::JOY_W-1:0] joy1,
	input  logic [mcr_input_pkg::JOY_W-1:0] joy2,
	input  logic [mcr_input_pkg::JOY_W-1:0] joy3,
	input  logic [mcr_input_pkg::ANA_W-1:0] joy1a,
	input  logic [mcr_input_pkg::ANA_W-1:0] joy2a,
	input  logic [7:0]                      cpu_out5,
	input  logic [7:0]                      cpu_out6,
	output logic                            core_reset,
	output mcr_input_pkg::port_byte_u       in_port0,
	output mcr_input_pkg::port_byte_u       in_port1,
	output mcr_input_pkg::port_byte_u       in_port2
);
	import mcr_input_pkg::*;

	logic [GEAR_W-1:0] gear1;
	logic [GEAR_W-1:0] gear2;
	logic [7:0]        adc_data;

	reset_holdoff_timer reset_holdoff_timer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.download   (download),
		.core_reset (core_reset)
	);

	// Fire A shifts up, fire B down, start drops to neutral
	gearbox_fsm gearbox_p1_i (
		.clk_sys    (clk_sys),
		.core_reset (core_reset),
		.shift_up   (joy1[BTN_FIRE_A]),
		.shift_down (joy1[BTN_FIRE_B]),
		.neutral    (joy1[BTN_START]),
		.gear       (gear1)
	);

	gearbox_fsm gearbox_p2_i (
		.clk_sys    (clk_sys),
		.core_reset (core_reset),
		.shift_up   (joy2[BTN_FIRE_A]),
		.shift_down (joy2[BTN_FIRE_B]),
		.neutral    (joy2[BTN_START]),
		.gear       (gear2)
	);

	adc_select adc_select_i (
		.clk_sys    (clk_sys),
		.core_reset (core_reset),
		.cpu_out5   (cpu_out5),
		.cpu_out6   (cpu_out6),
		.joy1a      (joy1a),
		.joy2a      (joy2a),
		.adc_data   (adc_data)
	);

	input_port_mux input_port_mux_i (
		.clk_sys    (clk_sys),
		.core_reset (core_reset),
		.cfg_wr     (cfg_wr),
		.cfg_index  (cfg_index),
		.cfg_data   (cfg_data),
		.joy1       (joy1),
		.joy2       (joy2),
		.joy3       (joy3),
		.gear1      (gear1),
		.gear2      (gear2),
		.adc_data   (adc_data),
		.in_port0   (in_port0),
		.in_port1   (in_port1),
		.in_port2   (in_port2)
	);

endmodule

// ==== tb_mcr_input_ref.svh ====
//====================
// Reference model and compare tasks for the MCR-3 input testbench.
// Included inside the testbench module after the package import.
//====================
`ifndef TB_MCR_INPUT_REF_SVH
`define TB_MCR_INPUT_REF_SVH

// Shifter switch pattern per gear
function automatic logic [3:0] gear_code(input logic [2:0] g);
	case (g)
		3'd1:    return 4'h5;
		3'd2:    return 4'h6;
		3'd3:    return 4'h1;
		3'd4:    return 4'h2;
		default: return 4'h0;
	endcase
endfunction

// Neutral first, then up, then down, saturating at 0 and 4
function automatic logic [2:0] ref_gear(input logic [2:0] g, input logic up, input logic down,
		input logic neutral);
	if (neutral)
		return 3'd0;
	if (up)
		return (g == 3'd4) ? g : g + 3'd1;
	if (down)
		return (g == 3'd0) ? g : g - 3'd1;
	return g;
endfunction

function automatic logic [7:0] ref_adc(input logic [1:0] ctl, input logic [15:0] a1,
		input logic [15:0] a2);
	logic signed [7:0] x1;
	logic signed [7:0] x2;
	logic [7:0]        h1;
	logic [7:0]        h2;
	x1 = a1[7:0];
	x2 = a2[7:0];
	h1 = x1 >>> 1;
	h2 = x2 >>> 1;
	case (ctl)
		2'd0:    return a2[15] ? {a2[14:8], 1'b1} : 8'hFF;
		2'd1:    return a1[15] ? {a1[14:8], 1'b1} : 8'hFF;
		2'd2:    return 8'h74 + h2;
		default: return 8'h74 - h1;
	endcase
endfunction

function automatic port_byte_u ref_port0(input logic [7:0] game, input logic [11:0] j1,
		input logic [11:0] j2, input logic [11:0] j3);
	port_byte_u p;
	p.raw = 8'hFF;
	if (game == GAME_MAXRPM)
		p.raw = ~{4'b0000, j1[BTN_START], j2[BTN_START], j1[BTN_COIN], j2[BTN_COIN]};
	else if (game == GAME_POWERDRIVE)
		p.raw = ~{5'b00000, j3[BTN_COIN], j2[BTN_COIN], j1[BTN_COIN]};
	return p;
endfunction

function automatic port_byte_u ref_port1(input logic [7:0] game, input logic [11:0] j1,
		input logic [11:0] j2, input logic [2:0] tog, input logic [7:0] adc);
	port_byte_u p;
	p.raw = 8'hFF;
	if (game == GAME_MAXRPM)
		p.raw = adc;
	else if (game == GAME_POWERDRIVE)
		p.raw = ~{j2[BTN_FIRE_B], j2[BTN_FIRE_A], tog[1], j2[BTN_FIRE_C],
			j1[BTN_FIRE_B], j1[BTN_FIRE_A], tog[0], j1[BTN_FIRE_C]};
	return p;
endfunction

function automatic port_byte_u ref_port2(input logic [7:0] game, input logic [11:0] j3,
		input logic [2:0] g1, input logic [2:0] g2, input logic [2:0] tog);
	port_byte_u p;
	p.raw = 8'hFF;
	if (game == GAME_MAXRPM)
		p.raw = ~{gear_code(g1), gear_code(g2)};
	else if (game == GAME_POWERDRIVE)
		p.raw = ~{4'b0000, j3[BTN_FIRE_B], j3[BTN_FIRE_A], tog[2], j3[BTN_FIRE_C]};
	return p;
endfunction

task automatic check_port(input string name, input port_byte_u expected, input port_byte_u actual);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("Fail %0t %s expected %02h actual %02h", $time, name, expected.raw, actual.raw);
	end
endtask

task automatic check_reset(input string name, input logic expected, input logic actual);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("Fail %0t %s expected %b actual %b", $time, name, expected, actual);
	end
endtask

`endif

// ==== tb_mcr_input.sv ====
//====================
// Testbench for the MCR-3 control-input block.
// Runs the reset sequence, then game select, Max RPM and Power Drive.
//====================
`timescale 1ns/1ps

module tb_mcr_input;
	import mcr_input_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int TEST_CYCLES = 300;

	logic             clk_sys;
	logic             reset;
	logic             download;
	logic             cfg_wr;
	logic             core_reset;
	logic [7:0]       cfg_index;
	logic [7:0]       cfg_data;
	logic [7:0]       cpu_out5;
	logic [7:0]       cpu_out6;
	logic [JOY_W-1:0] joy1;
	logic [JOY_W-1:0] joy2;
	logic [JOY_W-1:0] joy3;
	logic [ANA_W-1:0] joy1a;
	logic [ANA_W-1:0] joy2a;
	port_byte_u       in_port0;
	port_byte_u       in_port1;
	port_byte_u       in_port2;

	int     errors;
	int     checks;
	integer seed;
	logic   model_en;
	// Expected state that follows the stimulus
	logic [7:0] game_m;
	logic [2:0] gear1_m;
	logic [2:0] gear2_m;
	logic [2:0] tog_m;
	logic [2:0] fd_last_m;
	logic [1:0] last1_m;
	logic [1:0] last2_m;
	logic [1:0] adc_ctl_m;
	logic [2:0] fire_d;

	`include "tb_mcr_input_ref.svh"

	mcr_input_top dut_i (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	assign fire_d = {joy3[BTN_FIRE_D], joy2[BTN_FIRE_D], joy1[BTN_FIRE_D]};

	always @(posedge clk_sys) begin
		if (model_en) begin
			if (cfg_wr && cfg_index == CFG_INDEX_GAME)
				game_m <= cfg_data;
			if (cpu_out6[6:5] == 2'b00)
				adc_ctl_m <= cpu_out5[2:1];
			gear1_m <= ref_gear(gear1_m, joy1[BTN_FIRE_A] & ~last1_m[0],
				joy1[BTN_FIRE_B] & ~last1_m[1], joy1[BTN_START]);
			gear2_m <= ref_gear(gear2_m, joy2[BTN_FIRE_A] & ~last2_m[0],
				joy2[BTN_FIRE_B] & ~last2_m[1], joy2[BTN_START]);
			last1_m   <= {joy1[BTN_FIRE_B], joy1[BTN_FIRE_A]};
			last2_m   <= {joy2[BTN_FIRE_B], joy2[BTN_FIRE_A]};
			tog_m     <= tog_m ^ (fire_d & ~fd_last_m);
			fd_last_m <= fire_d;
		end
	end

	// Ports are settled by the falling edge
	always @(negedge clk_sys) begin
		if (model_en) begin
			check_reset("core_reset", 1'b0, core_reset);
			check_port("in_port0", ref_port0(game_m, joy1, joy2, joy3), in_port0);
			check_port("in_port1", ref_port1(game_m, joy1, joy2, tog_m,
				ref_adc(adc_ctl_m, joy1a, joy2a)), in_port1);
			check_port("in_port2", ref_port2(game_m, joy3, gear1_m, gear2_m, tog_m), in_port2);
		end
	end

	task automatic drive_sticks(input logic [JOY_W-1:0] j1, input logic [JOY_W-1:0] j2,
			input logic [JOY_W-1:0] j3, input logic [ANA_W-1:0] a1, input logic [ANA_W-1:0] a2);
		@(posedge clk_sys);
		joy1  <= j1;
		joy2  <= j2;
		joy3  <= j3;
		joy1a <= a1;
		joy2a <= a2;
	endtask

	task automatic write_cfg(input logic [7:0] index, input logic [7:0] data);
		@(posedge clk_sys);
		cfg_wr    <= 1'b1;
		cfg_index <= index;
		cfg_data  <= data;
		@(posedge clk_sys);
		cfg_wr    <= 1'b0;
	endtask

	task automatic write_cpu(input logic [7:0] out5, input logic [7:0] out6);
		@(posedge clk_sys);
		cpu_out5 <= out5;
		cpu_out6 <= out6;
	endtask

	// Core reset must stay high for the whole download and drop soon after
	task automatic run_download(input int cycles);
		int n;
		@(posedge clk_sys);
		download <= 1'b1;
		repeat (cycles) begin
			@(negedge clk_sys);
			check_reset("core_reset", 1'b1, core_reset);
		end
		@(posedge clk_sys);
		download <= 1'b0;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (core_reset && n < 4);
		if (core_reset) begin
			errors++;
			$display("core_reset stayed high after the download ended");
		end
	endtask

	task automatic random_sticks(input int cycles);
		logic [31:0] r;
		logic [31:0] r2;
		repeat (cycles) begin
			r  = $random(seed);
			r2 = $random(seed);
			drive_sticks(r[11:0], r[23:12], r2[11:0], r2[31:16], {r[31:24], r2[15:8]});
		end
	endtask

	initial begin
		int          n;
		logic [31:0] r;
		logic [31:0] r2;
		logic [11:0] j1;
		logic [11:0] j2;
		seed = 62656;
		errors = 0;
		checks = 0;
		model_en = 1'b0;
		clk_sys = 1'b0;
		reset = 1'b1;
		download = 1'b0;
		cfg_wr = 1'b0;
		cfg_index = '0;
		cfg_data = '0;
		cpu_out5 = '0;
		cpu_out6 = '0;
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		joy1a = '0;
		joy2a = '0;
		{game_m, gear1_m, gear2_m, tog_m, fd_last_m, last1_m, last2_m, adc_ctl_m} = '0;

		// Reset and download
		@(negedge clk_sys);
		check_reset("core_reset", 1'b1, core_reset);
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		// A short first download marks the ROM as loaded
		run_download(2);
		// In the second one only the download level holds the core
		run_download(8);
		n = 0;
		while (!core_reset && n < int'(HOLDOFF_CYCLES) + 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (!core_reset) begin
			errors++;
			$display("No second reset pulse arrived after the download");
		end
		@(negedge clk_sys);
		check_reset("core_reset", 1'b0, core_reset);
		@(posedge clk_sys);
		model_en <= 1'b1;

		// Game select
		random_sticks(6);
		write_cfg(8'd5, GAME_MAXRPM);
		random_sticks(3);
		write_cfg(CFG_INDEX_GAME, GAME_MAXRPM);

		// Max RPM gears climb, then descend, then mix with start
		for (int i = 0; i < 90; i++) begin
			r  = $random(seed);
			r2 = $random(seed);
			j1 = r[11:0];
			j2 = r[23:12];
			if (i < 60) begin
				j1[BTN_START] = 1'b0;
				j2[BTN_START] = 1'b0;
				j1[(i < 30) ? BTN_FIRE_B : BTN_FIRE_A] = 1'b0;
				j2[(i < 30) ? BTN_FIRE_B : BTN_FIRE_A] = 1'b0;
			end else begin
				j1[BTN_START] = (r2[2:0] == 3'd0);
				j2[BTN_START] = (r2[5:3] == 3'd0);
			end
			drive_sticks(j1, j2, r2[27:16], 16'h0000, 16'h0000);
		end

		// Max RPM ADC channels and ignored writes
		for (int ch = 0; ch < 4; ch++) begin
			r = $random(seed);
			write_cpu({r[7:3], ch[1:0], r[0]}, 8'h00);
			random_sticks(5);
		end
		write_cpu(8'h00, 8'h40);
		random_sticks(2);
		write_cpu(8'h02, 8'h20);
		random_sticks(2);
		write_cpu(8'h02, 8'h00);
		random_sticks(2);

		// Power Drive toggles and button layout
		write_cfg(CFG_INDEX_GAME, GAME_POWERDRIVE);
		repeat (6) drive_sticks(12'h080, 12'h080, 12'h080, 16'h0000, 16'h0000);
		repeat (2) drive_sticks(12'h000, 12'h000, 12'h000, 16'h0000, 16'h0000);
		repeat (3) drive_sticks(12'h080, 12'h000, 12'h080, 16'h0000, 16'h0000);
		random_sticks(60);

		@(negedge clk_sys);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		#(CLK_PERIOD * (TEST_CYCLES + int'(HOLDOFF_CYCLES) + 100));
		$display("Timeout, the tests did not reach the end, errors so far: %0d", errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
mcr_input_pkg.sv
gearbox_fsm.sv
reset_holdoff_timer.sv
adc_select.sv
input_port_mux.sv
mcr_input_top.sv
tb_mcr_input.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the MCR-3 input testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f build.f --top-module tb_mcr_input -o tb_mcr_input; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_mcr_input > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
